/* dv/fifo_trace.txt */
# Columns: command, then arguments. push and expect take a count and that many hex words.
# pop, blind and random take a count; full and empty take 0 or 1; data takes a hex word.
section reset_state
empty 1
full 0
data 00000000
end
section in_order
push 5 12345678 deadbeef 0badf00d a5a5a5a5 5a5a5a5a
expect 5 12345678 deadbeef 0badf00d a5a5a5a5 5a5a5a5a
pop 5
empty 1
data 5a5a5a5a
end
section fill_full
push 4 f0000000 f0000001 f0000002 f0000003
push 4 f0000004 f0000005 f0000006 f0000007
push 4 f0000008 f0000009 f000000a f000000b
push 3 f000000c f000000d f000000e
full 0
push 1 f000000f
full 1
push 2 dead0001 dead0002
full 1
expect 4 f0000000 f0000001 f0000002 f0000003
expect 4 f0000004 f0000005 f0000006 f0000007
expect 4 f0000008 f0000009 f000000a f000000b
expect 4 f000000c f000000d f000000e f000000f
pop 16
empty 1
blind 4
empty 1
data f000000f
end
section pop_empty
blind 3
data f000000f
push 2 c0ffee00 c0ffee01
expect 2 c0ffee00 c0ffee01
pop 2
blind 6
data c0ffee01
empty 1
end
section random_wrap
random 100
end
section random_short
random 48
end

/* list.f */
hw/fifo_pkg.sv
hw/ptr_sync.sv
hw/wr_ptr_full.sv
hw/rd_ptr_empty.sv
hw/bram_dp_2clk.sv
hw/async_fifo.sv
dv/clk_gen.sv
dv/tb_async_fifo.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the dual-clock FIFO testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_async_fifo -f list.f \
    -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Verification passed" sim.log; then
    echo "Simulation PASS"
else
    echo "Simulation FAIL, see sim.log"
    exit 1
fi

/* dv/tb_async_fifo.sv */
`timescale 1ns/1ps
// Testbench for the dual-clock FIFO
// Trace sections, LFSR random traffic, reference queue, watchdog

module tb_async_fifo;

    logic                        wr_clk;
    logic                        rd_clk;
    logic                        reset;
    logic                        push;
    logic [fifo_pkg::DATA_W-1:0] wr_data;
    logic                        full;
    logic                        pop;
    logic [fifo_pkg::DATA_W-1:0] rd_data;
    logic                        empty;

    logic [fifo_pkg::DATA_W-1:0] ref_q [$];    // Words the DUT has accepted
    logic [fifo_pkg::DATA_W-1:0] exp_q [$];    // Words the trace expects back
    string                       cmd_op [$];
    string                       cmd_name [$];
    logic [31:0]                 cmd_arg [$];
    logic [31:0]                 lfsr_state;
    string                       sec_name;
    int                          checks;
    int                          errors;
    int                          sec_checks;
    int                          sec_errors;
    int                          sections;
    int                          limit_cycles = 0;

    clk_gen #(.PERIOD_NS(100.0), .OFFSET_NS(0.0))  wr_clk_gen (.clk_o(wr_clk));
    clk_gen #(.PERIOD_NS(100.0), .OFFSET_NS(37.0)) rd_clk_gen (.clk_o(rd_clk));

    async_fifo DUT (
        .wr_clk_i  (wr_clk ),
        .rd_clk_i  (rd_clk ),
        .reset_i   (reset  ),
        .push_i    (push   ),
        .wr_data_i (wr_data),
        .full_o    (full   ),
        .pop_i     (pop    ),
        .rd_data_o (rd_data),
        .empty_o   (empty  )
    );

    // ************************************************************************
    // Helpers
    // ************************************************************************

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        sec_errors++;
        $display("ERROR at time %0t: %s", $time, msg);
    endtask

    task automatic check_cond(input bit ok, input string msg);
        checks++;
        sec_checks++;
        assert (ok) else begin
            errors++;
            sec_errors++;
            $display("CHECK FAILED at time %0t: %s", $time, msg);
        end
    endtask

    function automatic void add_cmd(input string op, input string name, input logic [31:0] arg);
        cmd_op.push_back(op);
        cmd_name.push_back(name);
        cmd_arg.push_back(arg);
    endfunction

    task automatic load_trace(output bit ok);
        int          fd;
        int          code;
        int          c;
        int          n;
        int          words;
        string       tok;
        logic [31:0] word;
        words = 0;
        fd = $fopen("dv/fifo_trace.txt", "r");
        ok = (fd != 0);
        if (!ok) begin
            $display("Could not open the trace file dv/fifo_trace.txt");
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok.substr(0, 0) == "#") begin
                    c = $fgetc(fd);
                    while (c != 10 && c != -1) begin
                        c = $fgetc(fd);
                    end
                end else if (tok == "section") begin
                    code = $fscanf(fd, "%s", tok);
                    ok   = ok && (code == 1);
                    add_cmd("section", tok, '0);
                end else if (tok == "push" || tok == "expect") begin
                    code = $fscanf(fd, "%d", n);
                    ok   = ok && (code == 1);
                    for (int k = 0; k < n; k++) begin
                        code = $fscanf(fd, "%h", word);
                        ok   = ok && (code == 1);
                        add_cmd(tok, "", word);
                    end
                    if (tok == "push") words += n;
                end else if (tok == "data") begin
                    code = $fscanf(fd, "%h", word);
                    ok   = ok && (code == 1);
                    add_cmd(tok, "", word);
                end else if (tok == "end") begin
                    add_cmd(tok, "", '0);
                end else begin
                    code = $fscanf(fd, "%d", n);
                    ok   = ok && (code == 1);
                    add_cmd(tok, "", n);
                    if (tok == "random") words += n;
                end
            end
            $fclose(fd);
            if (!ok) begin
                $display("The trace file dv/fifo_trace.txt has a command with a bad argument");
            end
            limit_cycles = words * 20 + 1000;
        end
    endtask

    // ************************************************************************
    // Write and read side drivers
    // ************************************************************************

    // Called one read cycle after an accepted pop
    task automatic take_popped_word(input bit directed);
        logic [fifo_pkg::DATA_W-1:0] want;
        assert (ref_q.size() > 0)
            else report_error("the DUT returned a word that was never pushed");
        if (ref_q.size() > 0) begin
            want = ref_q.pop_front();
            check_cond(rd_data == want, $sformatf("popped %h, reference has %h", rd_data, want));
        end
        if (directed) begin
            assert (exp_q.size() > 0)
                else report_error("more words popped than the trace expects");
            if (exp_q.size() > 0) begin
                want = exp_q.pop_front();
                check_cond(rd_data == want, $sformatf("popped %h, trace has %h", rd_data, want));
            end
        end
    endtask

    task automatic push_word(input logic [31:0] word);
        @(posedge wr_clk);
        #1;
        push    = 1'b1;
        wr_data = word;
        if (!full) ref_q.push_back(word);  // Taken at the coming edge
        @(posedge wr_clk);
        #1;
        push = 1'b0;
    endtask

    task automatic pop_word(input bit wait_data);
        logic [fifo_pkg::DATA_W-1:0] held;
        bit                          accepted;
        @(posedge rd_clk);
        #1;
        while (wait_data && empty) begin
            @(posedge rd_clk);
            #1;
        end
        pop      = 1'b1;
        accepted = !empty;
        held     = rd_data;
        @(posedge rd_clk);
        #1;
        pop = 1'b0;
        if (accepted) begin
            take_popped_word(1'b1);
        end else begin
            check_cond(rd_data == held, $sformatf("ignored pop changed rd_data_o to %h", rd_data));
        end
    endtask

    // Flags may lag the other side, but never claim room or data that is not there
    task automatic random_writer(input int n);
        int          sent;
        logic [31:0] go;
        sent = 0;
        while (sent < n) begin
            @(posedge wr_clk);
            #1;
            if (!full) check_cond(ref_q.size() < fifo_pkg::DEPTH, "full_o low with DEPTH words");
            go      = take_bits(2);
            push    = (go[1:0] != 2'b00);
            wr_data = take_bits(fifo_pkg::DATA_W);
            if (push && !full) begin
                ref_q.push_back(wr_data);
                sent++;
            end
        end
        @(posedge wr_clk);
        #1;
        push = 1'b0;
    endtask

    task automatic random_reader(input int n);
        int          got;
        bit          pending;
        logic [31:0] go;
        got     = 0;
        pending = 1'b0;
        while (got < n) begin
            @(posedge rd_clk);
            #1;
            if (pending) begin
                take_popped_word(1'b0);
                got++;
            end
            if (!empty) check_cond(ref_q.size() > 0, "empty_o low with no word stored");
            go      = take_bits(1);
            pop     = go[0] && (got < n);
            pending = pop && !empty;
        end
        pop = 1'b0;
    endtask

    // ************************************************************************
    // Trace sequencing
    // ************************************************************************

    task automatic close_section();
        assert (exp_q.size() == 0)
            else report_error("the trace expected words that never came");
        exp_q.delete();
        sections++;
        $display("section %s: %0d checks, %0d errors, %s", sec_name, sec_checks, sec_errors,
                 sec_errors == 0 ? "ok" : "FAILED");
    endtask

    task automatic run_trace();
        int n;
        for (int i = 0; i < cmd_op.size(); i++) begin
            n = cmd_arg[i];
            case (cmd_op[i])
                "section": begin
                    sec_name   = cmd_name[i];
                    sec_checks = 0;
                    sec_errors = 0;
                end
                "push":   push_word(cmd_arg[i]);
                "expect": exp_q.push_back(cmd_arg[i]);
                "pop":    repeat (n) pop_word(1'b1);
                "blind":  repeat (n) pop_word(1'b0);  // Pops whatever empty_o says
                "full":   check_cond(full == cmd_arg[i][0], $sformatf("full_o is %b", full));
                "empty":  check_cond(empty == cmd_arg[i][0], $sformatf("empty_o is %b", empty));
                "data":   check_cond(rd_data == cmd_arg[i], $sformatf("rd_data_o is %h", rd_data));
                "random": begin
                    fork
                        random_writer(n);
                        random_reader(n);
                    join
                end
                "end":    close_section();
                default:  report_error($sformatf("unknown trace command %s", cmd_op[i]));
            endcase
        end
    endtask

    initial begin
        bit loaded;
        reset      = 1'b1;
        push       = 1'b0;
        pop        = 1'b0;
        wr_data    = '0;
        lfsr_state = 32'hba103214;
        checks     = 0;
        errors     = 0;
        sections   = 0;
        load_trace(loaded);
        repeat (4) @(posedge wr_clk);
        #1;
        reset = 1'b0;
        if (loaded) run_trace();
        $display("sections %0d, checks %0d, errors %0d", sections, checks, errors);
        if (loaded && errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge wr_clk);
        $display("Timeout: the run did not end within %0d write clock cycles", limit_cycles);
        $display("Verification failed");
        $finish;
    end

endmodule

/* dv/clk_gen.sv */
`timescale 1ns/1ps
// Free-running testbench clock with a period and a start offset

module clk_gen #(
    parameter real PERIOD_NS = 100.0,
    parameter real OFFSET_NS = 0.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        #(OFFSET_NS);              // Phase shift against the other domain
        forever begin
            #(PERIOD_NS / 2.0);
            clk_o = ~clk_o;
        end
    end

endmodule

/* hw/async_fifo.sv */
`timescale 1ns/1ps
// Dual-clock FIFO top level
// Pointer logic for each side, storage and the two Gray pointer crossings

module async_fifo (
    input  logic                        wr_clk_i,
    input  logic                        rd_clk_i,
    input  logic                        reset_i,

    input  logic                        push_i,
    input  logic [fifo_pkg::DATA_W-1:0] wr_data_i,
    output logic                        full_o,

    input  logic                        pop_i,
    output logic [fifo_pkg::DATA_W-1:0] rd_data_o,
    output logic                        empty_o
);

    // Write domain
    logic                        wr_en;
    logic [fifo_pkg::ADDR_W-1:0] wr_addr;
    logic [fifo_pkg::PTR_W-1:0]  wr_gray;
    logic [fifo_pkg::PTR_W-1:0]  wr_side_rd_gray;

    // Read domain
    logic                        rd_en;
    logic [fifo_pkg::ADDR_W-1:0] rd_addr;
    logic [fifo_pkg::PTR_W-1:0]  rd_gray;
    logic [fifo_pkg::PTR_W-1:0]  rd_side_wr_gray;

    // ************************************************************************
    // Pointer logic
    // ************************************************************************

    wr_ptr_full i_wr_ptr_full (
        .wr_clk_i       (wr_clk_i       ),
        .reset_i        (reset_i        ),
        .push_i         (push_i         ),
        .rd_gray_sync_i (wr_side_rd_gray),
        .wr_en_o        (wr_en          ),
        .wr_addr_o      (wr_addr        ),
        .wr_gray_o      (wr_gray        ),
        .full_o         (full_o         )
    );

    rd_ptr_empty i_rd_ptr_empty (
        .rd_clk_i       (rd_clk_i       ),
        .reset_i        (reset_i        ),
        .pop_i          (pop_i          ),
        .wr_gray_sync_i (rd_side_wr_gray),
        .rd_en_o        (rd_en          ),
        .rd_addr_o      (rd_addr        ),
        .rd_gray_o      (rd_gray        ),
        .empty_o        (empty_o        )
    );

    // ************************************************************************
    // Storage
    // ************************************************************************

    bram_dp_2clk i_bram_dp_2clk (
        .wr_clk_i  (wr_clk_i ),
        .wr_en_i   (wr_en    ),
        .wr_addr_i (wr_addr  ),
        .wr_data_i (wr_data_i),
        .rd_clk_i  (rd_clk_i ),
        .reset_i   (reset_i  ),
        .rd_en_i   (rd_en    ),
        .rd_addr_i (rd_addr  ),
        .rd_data_o (rd_data_o)
    );

    // ************************************************************************
    // Clock domain crossings
    // ************************************************************************

    // Write pointer into the read domain
    ptr_sync wr_to_rd_sync (
        .clk_i   (rd_clk_i       ),
        .reset_i (reset_i        ),
        .gray_i  (wr_gray        ),
        .gray_o  (rd_side_wr_gray)
    );

    // Read pointer into the write domain
    ptr_sync rd_to_wr_sync (
        .clk_i   (wr_clk_i       ),
        .reset_i (reset_i        ),
        .gray_i  (rd_gray        ),
        .gray_o  (wr_side_rd_gray)
    );

endmodule

/* hw/bram_dp_2clk.sv */
`timescale 1ns/1ps
// Two-clock dual-port memory
// Write port on the write clock, registered read port on the read clock

module bram_dp_2clk (
    input  logic                        wr_clk_i,
    input  logic                        wr_en_i,
    input  logic [fifo_pkg::ADDR_W-1:0] wr_addr_i,
    input  logic [fifo_pkg::DATA_W-1:0] wr_data_i,

    input  logic                        rd_clk_i,
    input  logic                        reset_i,
    input  logic                        rd_en_i,
    input  logic [fifo_pkg::ADDR_W-1:0] rd_addr_i,
    output logic [fifo_pkg::DATA_W-1:0] rd_data_o
);

    logic [fifo_pkg::DATA_W-1:0] mem [fifo_pkg::DEPTH];
    logic [fifo_pkg::DATA_W-1:0] rd_data_q;

    // Write port
    always_ff @(posedge wr_clk_i) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Read port holds its word until the next enabled read
    always_ff @(posedge rd_clk_i) begin
        if (reset_i) begin
            rd_data_q <= '0;
        end else if (rd_en_i) begin
            rd_data_q <= mem[rd_addr_i];
        end
    end

    assign rd_data_o = rd_data_q;

endmodule

/* hw/rd_ptr_empty.sv */
`timescale 1ns/1ps
// Read side of the dual-clock FIFO
// Binary and Gray read pointers, pop acceptance, registered empty flag

module rd_ptr_empty (
    input  logic                        rd_clk_i,
    input  logic                        reset_i,
    input  logic                        pop_i,
    input  logic [fifo_pkg::PTR_W-1:0]  wr_gray_sync_i,
    output logic                        rd_en_o,
    output logic [fifo_pkg::ADDR_W-1:0] rd_addr_o,
    output logic [fifo_pkg::PTR_W-1:0]  rd_gray_o,
    output logic                        empty_o
);

    logic [fifo_pkg::PTR_W-1:0] rd_bin_q;
    logic [fifo_pkg::PTR_W-1:0] rd_bin_next;
    logic [fifo_pkg::PTR_W-1:0] rd_gray_q;
    logic [fifo_pkg::PTR_W-1:0] rd_gray_next;
    logic                       empty_q;
    logic                       empty_next;

    // ************************************************************************
    // Pointer update
    // ************************************************************************

    assign rd_en_o = pop_i & ~empty_q;  // Accepted pop

    assign rd_bin_next  = rd_bin_q + {{(fifo_pkg::PTR_W-1){1'b0}}, rd_en_o};
    assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;

    // Caught up with the write pointer
    assign empty_next = (rd_gray_next == wr_gray_sync_i);

    always_ff @(posedge rd_clk_i) begin
        if (reset_i) begin
            rd_bin_q  <= '0;
            rd_gray_q <= '0;
            empty_q   <= 1'b1;
        end else begin
            rd_bin_q  <= rd_bin_next;
            rd_gray_q <= rd_gray_next;
            empty_q   <= empty_next;
        end
    end

    assign rd_addr_o = rd_bin_q[fifo_pkg::ADDR_W-1:0];
    assign rd_gray_o = rd_gray_q;
    assign empty_o   = empty_q;

    // ************************************************************************
    // Assertions
    // ************************************************************************

    // No pop may pass while empty
    a_no_adv_empty: assert property (@(posedge rd_clk_i) disable iff (reset_i)
        empty_o |=> $stable(rd_bin_q));

    // Single bit steps keep the write side sample coherent
    a_gray_step: assert property (@(posedge rd_clk_i) disable iff (reset_i)
        $onehot0(rd_gray_q ^ $past(rd_gray_q)));

endmodule

/* hw/wr_ptr_full.sv */
`timescale 1ns/1ps
// Write side of the dual-clock FIFO
// Binary and Gray write pointers, push acceptance, registered full flag

module wr_ptr_full (
    input  logic                        wr_clk_i,
    input  logic                        reset_i,
    input  logic                        push_i,
    input  logic [fifo_pkg::PTR_W-1:0]  rd_gray_sync_i,
    output logic                        wr_en_o,
    output logic [fifo_pkg::ADDR_W-1:0] wr_addr_o,
    output logic [fifo_pkg::PTR_W-1:0]  wr_gray_o,
    output logic                        full_o
);

    logic [fifo_pkg::PTR_W-1:0] wr_bin_q;
    logic [fifo_pkg::PTR_W-1:0] wr_bin_next;
    logic [fifo_pkg::PTR_W-1:0] wr_gray_q;
    logic [fifo_pkg::PTR_W-1:0] wr_gray_next;
    logic [fifo_pkg::PTR_W-1:0] rd_gray_lap;
    logic                       full_q;
    logic                       full_next;

    // ************************************************************************
    // Pointer update
    // ************************************************************************

    assign wr_en_o = push_i & ~full_q;  // Accepted push

    assign wr_bin_next  = wr_bin_q + {{(fifo_pkg::PTR_W-1){1'b0}}, wr_en_o};
    assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;

    // Read pointer one full lap behind, in Gray code
    assign rd_gray_lap = {~rd_gray_sync_i[fifo_pkg::PTR_W-1 -: 2],
                          rd_gray_sync_i[fifo_pkg::PTR_W-3:0]};

    assign full_next = (wr_gray_next == rd_gray_lap);

    always_ff @(posedge wr_clk_i) begin
        if (reset_i) begin
            wr_bin_q  <= '0;
            wr_gray_q <= '0;
            full_q    <= 1'b0;
        end else begin
            wr_bin_q  <= wr_bin_next;
            wr_gray_q <= wr_gray_next;
            full_q    <= full_next;   // Rises with the DEPTH-th word
        end
    end

    assign wr_addr_o = wr_bin_q[fifo_pkg::ADDR_W-1:0];
    assign wr_gray_o = wr_gray_q;
    assign full_o    = full_q;

    // ************************************************************************
    // Assertions
    // ************************************************************************

    // A refused push must not move the pointer
    a_no_adv_full: assert property (@(posedge wr_clk_i) disable iff (reset_i)
        full_o |=> $stable(wr_bin_q));

    // The read side samples this bus asynchronously
    a_gray_step: assert property (@(posedge wr_clk_i) disable iff (reset_i)
        $onehot0(wr_gray_q ^ $past(wr_gray_q)));

endmodule

/* hw/ptr_sync.sv */
`timescale 1ns/1ps
// Multi-flop synchronizer for a Gray pointer entering a new clock domain

module ptr_sync (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic [fifo_pkg::PTR_W-1:0] gray_i,
    output logic [fifo_pkg::PTR_W-1:0] gray_o
);

    // Stage 0 is the metastable capture flop
    logic [fifo_pkg::PTR_W-1:0] sync_q [fifo_pkg::SYNC_STAGES];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < fifo_pkg::SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= gray_i;
            for (int i = 1; i < fifo_pkg::SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign gray_o = sync_q[fifo_pkg::SYNC_STAGES-1];  // Last stage only

endmodule

/* hw/fifo_pkg.sv */
// Shared sizes for the dual-clock FIFO
// Word width, depth, address and pointer widths, synchronizer length

package fifo_pkg;

    // ************************************************************************
    // Storage
    // ************************************************************************

    localparam int DATA_W = 32;             // Bits per FIFO word
    localparam int DEPTH  = 16;             // Must stay a power of two
    localparam int ADDR_W = $clog2(DEPTH);  // Memory address bits

    // ************************************************************************
    // Pointers and crossing
    // ************************************************************************

    // One extra bit tells a full FIFO from an empty one
    localparam int PTR_W = ADDR_W + 1;

    // Flops per Gray pointer crossing
    localparam int SYNC_STAGES = 2;

endpackage
